/* src/lite_demux_macros.svh */
// fixed four-port build; LD_SEL_W must equal clog2(LD_NUM_PORTS) and LD_MAX_TRANS must be >= 2
`ifndef LITE_DEMUX_MACROS_SVH
`define LITE_DEMUX_MACROS_SVH

// ----------------------------------------------------------------------
// port count and select width
// ----------------------------------------------------------------------
// downstream ports behind the demux
`define LD_NUM_PORTS 4
// bits needed to name one downstream port
`define LD_SEL_W 2

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define LD_ADDR_W 32
`define LD_DATA_W 32
// one strobe bit per data byte
`define LD_STRB_W 4

// ----------------------------------------------------------------------
// outstanding transactions
// ----------------------------------------------------------------------
// depth of each select fifo, bounds open requests per channel
`define LD_MAX_TRANS 4

`endif

/* src/lite_demux_pkg.sv */
// AXI4-Lite channel structs only; prot is fixed at 3 bits and the widths come from the macros header
`include "lite_demux_macros.svh"

package lite_demux_pkg;

  // index of one downstream port
  typedef logic [`LD_SEL_W-1:0] sel_t;

  // address channels, address plus protection bits
  typedef struct packed {
    logic [`LD_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } aw_chan_t;

  typedef struct packed {
    logic [`LD_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } ar_chan_t;

  // write data beat
  typedef struct packed {
    logic [`LD_DATA_W-1:0] data;
    logic [`LD_STRB_W-1:0] strb;
  } w_chan_t;

  // write response, just the code
  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  // read data plus response code
  typedef struct packed {
    logic [`LD_DATA_W-1:0] data;
    logic [1:0]            resp;
  } r_chan_t;

  // master to slave direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  // slave to master direction
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } lite_resp_t;

endpackage

/* src/demux_sel_fifo.sv */
// push while full and pop while empty are dropped; no fall-through, head is valid only when not empty
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module demux_sel_fifo import lite_demux_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  sel_t sel_i,
  input  logic pop_i,
  output sel_t sel_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned ptr_w = $clog2(`LD_MAX_TRANS);
  localparam int unsigned cnt_w = $clog2(`LD_MAX_TRANS + 1);

  sel_t             mem_q [`LD_MAX_TRANS];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             do_push, do_pop;

  assign full_o  = (cnt_q == cnt_w'(`LD_MAX_TRANS));
  assign empty_o = (cnt_q == '0);
  // qualified handshakes
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  // head entry
  assign sel_o   = mem_q[rd_ptr_q];

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        // wrap at last entry
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`LD_MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`LD_MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave count alone
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= sel_i;
    end
  end

endmodule

/* src/demux_aw_route.sv */
// aw_sel_i must stay stable while aw_valid_i is high; the select is pushed once per address
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module demux_aw_route import lite_demux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // upstream address
  input  aw_chan_t                 aw_i,
  input  logic                     aw_valid_i,
  input  sel_t                     aw_sel_i,
  output logic                     aw_ready_o,
  // downstream addresses
  output aw_chan_t                 mst_aw_o,
  output logic [`LD_NUM_PORTS-1:0] mst_aw_valid_o,
  input  logic [`LD_NUM_PORTS-1:0] mst_aw_ready_i,
  // W select fifo
  input  logic                     fifo_full_i,
  output logic                     fifo_push_o
);

  // set while a pushed address waits for its slave
  logic lock_q, lock_d;

  // same address for every port, only the valid is steered
  assign mst_aw_o = aw_i;

  // ----------------------------------------------------------------------
  // handshake control
  // ----------------------------------------------------------------------
  always_comb begin
    lock_d         = lock_q;
    aw_ready_o     = 1'b0;
    mst_aw_valid_o = '0;
    fifo_push_o    = 1'b0;
    if (lock_q) begin
      // select already queued, keep valid up
      mst_aw_valid_o[aw_sel_i] = 1'b1;
      if (mst_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !fifo_full_i) begin
      // new address, queue select now
      fifo_push_o              = 1'b1;
      mst_aw_valid_o[aw_sel_i] = 1'b1;
      if (mst_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
      end else begin
        // slave stalls, avoid a second push
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

/* src/demux_ar_route.sv */
// ar_sel_i must stay stable while ar_valid_i is high; a full R fifo stalls all reads
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module demux_ar_route import lite_demux_pkg::*; (
  // upstream address
  input  ar_chan_t                 ar_i,
  input  logic                     ar_valid_i,
  input  sel_t                     ar_sel_i,
  output logic                     ar_ready_o,
  // downstream addresses
  output ar_chan_t                 mst_ar_o,
  output logic [`LD_NUM_PORTS-1:0] mst_ar_valid_o,
  input  logic [`LD_NUM_PORTS-1:0] mst_ar_ready_i,
  // R select fifo
  input  logic                     fifo_full_i,
  output logic                     fifo_push_o
);

  // broadcast address payload
  assign mst_ar_o = ar_i;

  // valid only toward the selected slave, only with fifo room
  for (genvar i = 0; i < `LD_NUM_PORTS; i++) begin : gen_ar_valid
    assign mst_ar_valid_o[i] = ar_valid_i & ~fifo_full_i & (ar_sel_i == sel_t'(i));
  end

  // ready from the selected slave
  assign ar_ready_o = ~fifo_full_i & mst_ar_ready_i[ar_sel_i];

  // one push per accepted read
  assign fifo_push_o = ar_valid_i & ar_ready_o;

endmodule

/* src/demux_w_route.sv */
// write beats follow AW order; a beat waits for a queued AW select and room in the B fifo
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module demux_w_route import lite_demux_pkg::*; (
  // upstream write data
  input  w_chan_t                  w_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  // oldest write select and fifo state
  input  sel_t                     w_sel_i,
  input  logic                     w_fifo_empty_i,
  input  logic                     b_fifo_full_i,
  // downstream write data
  output w_chan_t                  mst_w_o,
  output logic [`LD_NUM_PORTS-1:0] mst_w_valid_o,
  input  logic [`LD_NUM_PORTS-1:0] mst_w_ready_i,
  output logic                     w_done_o
);

  logic route_ok;

  // known target and somewhere to park the B select
  assign route_ok = ~w_fifo_empty_i & ~b_fifo_full_i;

  assign mst_w_o = w_i;

  for (genvar i = 0; i < `LD_NUM_PORTS; i++) begin : gen_w_valid
    assign mst_w_valid_o[i] = w_valid_i & route_ok & (w_sel_i == sel_t'(i));
  end

  assign w_ready_o = route_ok & mst_w_ready_i[w_sel_i];
  // beat accepted upstream
  assign w_done_o  = w_valid_i & w_ready_o;

endmodule

/* src/demux_resp_route.sv */
// response mux for B or R; output payload is zero while no request is outstanding
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module demux_resp_route import lite_demux_pkg::*; #(
  parameter type chan_t = logic
) (
  // oldest outstanding select
  input  sel_t                      sel_i,
  input  logic                      fifo_empty_i,
  // downstream responses
  input  chan_t [`LD_NUM_PORTS-1:0] mst_rsp_i,
  input  logic  [`LD_NUM_PORTS-1:0] mst_rsp_valid_i,
  output logic  [`LD_NUM_PORTS-1:0] mst_rsp_ready_o,
  // upstream response
  output chan_t                     rsp_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic                      pop_o
);

  // ----------------------------------------------------------------------
  // response select
  // ----------------------------------------------------------------------
  // take payload only from the head slave
  assign rsp_o       = fifo_empty_i ? chan_t'('0) : mst_rsp_i[sel_i];
  assign rsp_valid_o = ~fifo_empty_i & mst_rsp_valid_i[sel_i];

  // ready goes to the head slave alone
  for (genvar i = 0; i < `LD_NUM_PORTS; i++) begin : gen_rsp_ready
    assign mst_rsp_ready_o[i] = ~fifo_empty_i & rsp_ready_i & (sel_i == sel_t'(i));
  end

  // response delivered, retire the select
  assign pop_o = rsp_valid_o & rsp_ready_i;

endmodule

/* src/lite_demux.sv */
// AXI4-Lite 1-to-4 demux, fully combinational paths; selects must be stable while valid is high
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module lite_demux import lite_demux_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // upstream port
  input  lite_req_t                      slv_req_i,
  input  sel_t                           slv_aw_sel_i,
  input  sel_t                           slv_ar_sel_i,
  output lite_resp_t                     slv_resp_o,
  // downstream ports
  output lite_req_t  [`LD_NUM_PORTS-1:0] mst_req_o,
  input  lite_resp_t [`LD_NUM_PORTS-1:0] mst_resp_i
);

  // ----------------------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------------------
  aw_chan_t                            mst_aw;
  ar_chan_t                            mst_ar;
  w_chan_t                             mst_w;
  logic      [`LD_NUM_PORTS-1:0]       aw_valid, aw_ready, ar_valid, ar_ready;
  logic      [`LD_NUM_PORTS-1:0]       w_valid, w_ready;
  b_chan_t   [`LD_NUM_PORTS-1:0]       b_chan;
  r_chan_t   [`LD_NUM_PORTS-1:0]       r_chan;
  logic      [`LD_NUM_PORTS-1:0]       b_valid, b_ready, r_valid, r_ready;
  // select fifo handshakes
  logic                                w_push, w_full, w_empty, w_done;
  logic                                b_full, b_empty, b_pop;
  logic                                r_push, r_full, r_empty, r_pop;
  sel_t                                w_sel, b_sel, r_sel;

  // unpack / pack the downstream structs
  for (genvar i = 0; i < `LD_NUM_PORTS; i++) begin : gen_ports
    assign mst_req_o[i].aw       = mst_aw;
    assign mst_req_o[i].aw_valid = aw_valid[i];
    assign mst_req_o[i].w        = mst_w;
    assign mst_req_o[i].w_valid  = w_valid[i];
    assign mst_req_o[i].b_ready  = b_ready[i];
    assign mst_req_o[i].ar       = mst_ar;
    assign mst_req_o[i].ar_valid = ar_valid[i];
    assign mst_req_o[i].r_ready  = r_ready[i];
    assign aw_ready[i]           = mst_resp_i[i].aw_ready;
    assign w_ready[i]            = mst_resp_i[i].w_ready;
    assign b_chan[i]             = mst_resp_i[i].b;
    assign b_valid[i]            = mst_resp_i[i].b_valid;
    assign ar_ready[i]           = mst_resp_i[i].ar_ready;
    assign r_chan[i]             = mst_resp_i[i].r;
    assign r_valid[i]            = mst_resp_i[i].r_valid;
  end

  // ----------------------------------------------------------------------
  // write path
  // ----------------------------------------------------------------------
  demux_aw_route u_aw_route (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .aw_i           (slv_req_i.aw),
    .aw_valid_i     (slv_req_i.aw_valid),
    .aw_sel_i       (slv_aw_sel_i),
    .aw_ready_o     (slv_resp_o.aw_ready),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (aw_valid),
    .mst_aw_ready_i (aw_ready),
    .fifo_full_i    (w_full),
    .fifo_push_o    (w_push)
  );

  // AW order for the data beats
  demux_sel_fifo u_w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_push),
    .sel_i   (slv_aw_sel_i),
    .pop_i   (w_done),
    .sel_o   (w_sel),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  demux_w_route u_w_route (
    .w_i            (slv_req_i.w),
    .w_valid_i      (slv_req_i.w_valid),
    .w_ready_o      (slv_resp_o.w_ready),
    .w_sel_i        (w_sel),
    .w_fifo_empty_i (w_empty),
    .b_fifo_full_i  (b_full),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (w_valid),
    .mst_w_ready_i  (w_ready),
    .w_done_o       (w_done)
  );

  // finished beat moves its select over to the B side
  demux_sel_fifo u_b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_done),
    .sel_i   (w_sel),
    .pop_i   (b_pop),
    .sel_o   (b_sel),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  demux_resp_route #(
    .chan_t (b_chan_t)
  ) u_b_route (
    .sel_i           (b_sel),
    .fifo_empty_i    (b_empty),
    .mst_rsp_i       (b_chan),
    .mst_rsp_valid_i (b_valid),
    .mst_rsp_ready_o (b_ready),
    .rsp_o           (slv_resp_o.b),
    .rsp_valid_o     (slv_resp_o.b_valid),
    .rsp_ready_i     (slv_req_i.b_ready),
    .pop_o           (b_pop)
  );

  // ----------------------------------------------------------------------
  // read path
  // ----------------------------------------------------------------------
  demux_ar_route u_ar_route (
    .ar_i           (slv_req_i.ar),
    .ar_valid_i     (slv_req_i.ar_valid),
    .ar_sel_i       (slv_ar_sel_i),
    .ar_ready_o     (slv_resp_o.ar_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (ar_valid),
    .mst_ar_ready_i (ar_ready),
    .fifo_full_i    (r_full),
    .fifo_push_o    (r_push)
  );

  demux_sel_fifo u_r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (r_push),
    .sel_i   (slv_ar_sel_i),
    .pop_i   (r_pop),
    .sel_o   (r_sel),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  demux_resp_route #(
    .chan_t (r_chan_t)
  ) u_r_route (
    .sel_i           (r_sel),
    .fifo_empty_i    (r_empty),
    .mst_rsp_i       (r_chan),
    .mst_rsp_valid_i (r_valid),
    .mst_rsp_ready_o (r_ready),
    .rsp_o           (slv_resp_o.r),
    .rsp_valid_o     (slv_resp_o.r_valid),
    .rsp_ready_i     (slv_req_i.r_ready),
    .pop_o           (r_pop)
  );

endmodule

/* dv/tb_clk_gen.sv */
// free-running 4 ns clock; reset is released 0.5 ns after the third rising edge
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    // hold reset for three cycles
    repeat (3) @(posedge clk_o);
    #0.5 rst_n_o = 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

/* dv/tb_checker.sv */
// samples at the falling edge; expected values come from dv/lite_demux_trace.txt
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module tb_checker import lite_demux_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [1:0]                     phase_i,
  input  logic [4:0]                     test_done_i,
  input  lite_req_t                      slv_req_i,
  input  lite_resp_t                     slv_resp_i,
  input  lite_req_t  [`LD_NUM_PORTS-1:0] mst_req_i,
  input  lite_resp_t [`LD_NUM_PORTS-1:0] mst_resp_i,
  output int                             pass_cnt_o,
  output int                             fail_cnt_o
);

  // fixed payload bits that the master drives
  localparam logic [2:0]            exp_aw_prot = 3'b010;
  localparam logic [2:0]            exp_ar_prot = 3'b001;
  localparam logic [`LD_STRB_W-1:0] exp_strb    = 4'hf;

  string        test_name [5] = '{"reset_idle", "write_route", "read_route",
                                  "resp_order", "ar_limit"};
  int           errs [5];
  logic [4:0]   reported;
  logic [103:0] trace_mem [64];
  logic [31:0]  wr_addr [$];
  logic [31:0]  wr_data [$];
  logic [31:0]  rd_addr [$];
  logic [31:0]  rd_exp [$];
  int           wr_sel [$];
  int           rd_sel [$];
  int           nw, nr;
  int           aw_k, w_k, ar_k, b_k, r_k, ar_up, full_cycles;

  initial begin
    pass_cnt_o  = 0;
    fail_cnt_o  = 0;
    reported    = '0;
    aw_k        = 0;
    w_k         = 0;
    ar_k        = 0;
    b_k         = 0;
    r_k         = 0;
    ar_up       = 0;
    full_cycles = 0;
    foreach (errs[t]) errs[t] = 0;
    foreach (trace_mem[i]) trace_mem[i] = '1;
    $readmemh("dv/lite_demux_trace.txt", trace_mem);
    foreach (trace_mem[i]) begin
      if (trace_mem[i][103:100] == 4'h0) begin
        wr_sel.push_back(int'(trace_mem[i][99:96]));
        wr_addr.push_back(trace_mem[i][95:64]);
        wr_data.push_back(trace_mem[i][63:32]);
      end else if (trace_mem[i][103:100] == 4'h1) begin
        rd_sel.push_back(int'(trace_mem[i][99:96]));
        rd_addr.push_back(trace_mem[i][95:64]);
        rd_exp.push_back(trace_mem[i][31:0]);
      end
    end
    nw = wr_sel.size();
    nr = rd_sel.size();
  end

  task automatic value_err(input int t, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    $display("ERROR %s %s: expected %h, actual %h", test_name[t], what, exp, act);
    errs[t]++;
  endtask

  task automatic plain_err(input int t, input string msg);
    $display("FAIL in %s: %s", test_name[t], msg);
    errs[t]++;
  endtask

  // ----------------------------------------------------------------------
  // per-cycle checks
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin : watch
    int n_aw, n_w, n_ar, b_port, r_port;
    if (rst_n_i) begin
      n_aw   = 0;
      n_w    = 0;
      n_ar   = 0;
      b_port = -1;
      r_port = -1;
      if (phase_i == 2'd0) begin
        for (int p = 0; p < `LD_NUM_PORTS; p++) begin
          if (mst_req_i[p].aw_valid || mst_req_i[p].w_valid || mst_req_i[p].ar_valid)
            plain_err(0, "downstream valid high before any stimulus");
        end
        if (slv_resp_i.aw_ready || slv_resp_i.w_ready || slv_resp_i.ar_ready ||
            slv_resp_i.b_valid || slv_resp_i.r_valid)
          plain_err(0, "upstream ready or response valid high after reset");
      end
      // ar_ready must drop while every read slot is taken
      if (ar_up - r_k == `LD_MAX_TRANS && slv_resp_i.ar_ready)
        plain_err(4, "ar_ready high with all read slots in use");
      if (phase_i == 2'd3 && ar_up - r_k == `LD_MAX_TRANS && slv_req_i.ar_valid)
        full_cycles++;
      for (int p = 0; p < `LD_NUM_PORTS; p++) begin
        n_aw += int'(mst_req_i[p].aw_valid);
        n_w  += int'(mst_req_i[p].w_valid);
        n_ar += int'(mst_req_i[p].ar_valid);
        if (mst_resp_i[p].b_valid && mst_req_i[p].b_ready) b_port = p;
        if (mst_resp_i[p].r_valid && mst_req_i[p].r_ready) r_port = p;
        // only the oldest request's slave may see a response ready
        if (mst_req_i[p].b_ready && b_k < nw && p != wr_sel[b_k])
          value_err(3, "b_ready port", wr_sel[b_k], p);
        if (mst_req_i[p].r_ready && p != rd_sel[r_k % nr])
          value_err(3, "r_ready port", rd_sel[r_k % nr], p);
        if (mst_req_i[p].aw_valid && mst_resp_i[p].aw_ready) begin
          if (aw_k >= nw) begin
            plain_err(1, "AW transfer beyond the trace");
          end else begin
            if (p != wr_sel[aw_k]) value_err(1, "aw port", wr_sel[aw_k], p);
            if (mst_req_i[p].aw.addr != wr_addr[aw_k])
              value_err(1, "aw addr", wr_addr[aw_k], mst_req_i[p].aw.addr);
          end
          if (mst_req_i[p].aw.prot != exp_aw_prot)
            value_err(1, "aw prot", exp_aw_prot, mst_req_i[p].aw.prot);
          aw_k++;
        end
        if (mst_req_i[p].w_valid && mst_resp_i[p].w_ready) begin
          if (w_k >= nw) begin
            plain_err(1, "W transfer beyond the trace");
          end else begin
            if (p != wr_sel[w_k]) value_err(1, "w port", wr_sel[w_k], p);
            if (mst_req_i[p].w.data != wr_data[w_k])
              value_err(1, "w data", wr_data[w_k], mst_req_i[p].w.data);
          end
          if (mst_req_i[p].w.strb != exp_strb)
            value_err(1, "w strb", exp_strb, mst_req_i[p].w.strb);
          w_k++;
        end
        if (mst_req_i[p].ar_valid && mst_resp_i[p].ar_ready) begin
          if (p != rd_sel[ar_k % nr]) value_err(2, "ar port", rd_sel[ar_k % nr], p);
          if (mst_req_i[p].ar.addr != rd_addr[ar_k % nr])
            value_err(2, "ar addr", rd_addr[ar_k % nr], mst_req_i[p].ar.addr);
          if (mst_req_i[p].ar.prot != exp_ar_prot)
            value_err(2, "ar prot", exp_ar_prot, mst_req_i[p].ar.prot);
          ar_k++;
        end
      end
      if (n_aw > 1) plain_err(1, "more than one downstream AW valid");
      if (n_w > 1) plain_err(1, "more than one downstream W valid");
      if (n_ar > 1) plain_err(2, "more than one downstream AR valid");
      if (slv_req_i.ar_valid && slv_resp_i.ar_ready) ar_up++;
      // responses in request order
      if (slv_resp_i.b_valid && slv_req_i.b_ready) begin
        if (b_k >= nw) plain_err(3, "B response without a write");
        else if (b_port != wr_sel[b_k]) value_err(3, "b port", wr_sel[b_k], b_port);
        if (slv_resp_i.b.resp != 2'b00) value_err(3, "b resp", 0, slv_resp_i.b.resp);
        b_k++;
      end
      if (slv_resp_i.r_valid && slv_req_i.r_ready) begin
        if (r_port != rd_sel[r_k % nr]) value_err(3, "r port", rd_sel[r_k % nr], r_port);
        if (slv_resp_i.r.data != rd_exp[r_k % nr])
          value_err(2, "r data", rd_exp[r_k % nr], slv_resp_i.r.data);
        if (slv_resp_i.r.resp != 2'b00) value_err(3, "r resp", 0, slv_resp_i.r.resp);
        r_k++;
      end
    end
    // one line per finished test
    for (int t = 0; t < 5; t++) begin
      if (test_done_i[t] && !reported[t]) begin
        if (t == 1 && (aw_k != nw || w_k != nw)) plain_err(1, "write count mismatch");
        if (t == 4 && full_cycles == 0) plain_err(4, "read limit never reached");
        if (errs[t] == 0) begin
          $display("test %s: ok", test_name[t]);
          pass_cnt_o++;
        end else begin
          $display("test %s: FAILED with %0d errors", test_name[t], errs[t]);
          fail_cnt_o++;
        end
        reported[t] = 1'b1;
      end
    end
  end

endmodule

/* dv/tb_lite_demux.sv */
// drives the demux from dv/lite_demux_trace.txt; needs at least LD_MAX_TRANS + 1 reads in the trace
`timescale 1ns/1ps
`include "lite_demux_macros.svh"

module tb_lite_demux import lite_demux_pkg::*; ();

  logic                           clk, rst_n;
  lite_req_t                      slv_req;
  sel_t                           aw_sel, ar_sel;
  lite_resp_t                     slv_resp;
  lite_req_t  [`LD_NUM_PORTS-1:0] mst_req;
  lite_resp_t [`LD_NUM_PORTS-1:0] mst_resp;
  // test control
  logic [1:0]   phase;
  logic [4:0]   test_done;
  logic         r_stall;
  int           pass_cnt, fail_cnt;
  // trace contents
  logic [103:0] trace_mem [64];
  logic [31:0]  wr_addr [$];
  logic [31:0]  wr_data [$];
  logic [31:0]  rd_addr [$];
  sel_t         wr_sel [$];
  sel_t         rd_sel [$];
  int           nw, nr, n_lines;
  // upstream progress
  int           aw_idx, w_idx, ar_idx, ar_lim, b_cnt, r_cnt;
  logic [31:0]  lfsr_q;
  // slave models
  logic [31:0]  s_aw_q [`LD_NUM_PORTS][$];
  logic [31:0]  s_w_q [`LD_NUM_PORTS][$];
  logic [31:0]  s_r_q [`LD_NUM_PORTS][$];
  int           s_b_pend [`LD_NUM_PORTS];
  logic [31:0]  s_mem [logic [33:0]];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lite_demux dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .slv_req_i    (slv_req),
    .slv_aw_sel_i (aw_sel),
    .slv_ar_sel_i (ar_sel),
    .slv_resp_o   (slv_resp),
    .mst_req_o    (mst_req),
    .mst_resp_i   (mst_resp)
  );

  tb_checker u_checker (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .phase_i      (phase),
    .test_done_i  (test_done),
    .slv_req_i    (slv_req),
    .slv_resp_i   (slv_resp),
    .mst_req_i    (mst_req),
    .mst_resp_i   (mst_resp),
    .pass_cnt_o   (pass_cnt),
    .fail_cnt_o   (fail_cnt)
  );

  // ----------------------------------------------------------------------
  // galois lfsr x^32+x^22+x^2+x+1 for random bits
  // ----------------------------------------------------------------------
  function automatic logic rnd_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  // odd ports answer slower than even ones
  function automatic logic ready_bit(input int p);
    logic a, b;
    a = rnd_bit();
    b = rnd_bit();
    return (p % 2 == 1) ? (a & b) : (a | b);
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  // ----------------------------------------------------------------------
  // bus sampled at negedge and driven 0.5 ns after posedge
  // ----------------------------------------------------------------------
  initial begin : bus_loop
    logic [`LD_NUM_PORTS-1:0] aw_hs, w_hs, ar_hs, b_hs, r_hs;
    logic [31:0]              aw_addr_s, w_data_s, ar_addr_s, a, d;
    logic                     up_aw, up_w, up_ar, up_b, up_r, act;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      for (int p = 0; p < `LD_NUM_PORTS; p++) begin
        aw_hs[p] = mst_req[p].aw_valid & mst_resp[p].aw_ready;
        w_hs[p]  = mst_req[p].w_valid & mst_resp[p].w_ready;
        ar_hs[p] = mst_req[p].ar_valid & mst_resp[p].ar_ready;
        b_hs[p]  = mst_resp[p].b_valid & mst_req[p].b_ready;
        r_hs[p]  = mst_resp[p].r_valid & mst_req[p].r_ready;
      end
      // payloads go to every port alike
      aw_addr_s = mst_req[0].aw.addr;
      w_data_s  = mst_req[0].w.data;
      ar_addr_s = mst_req[0].ar.addr;
      up_aw = slv_req.aw_valid & slv_resp.aw_ready;
      up_w  = slv_req.w_valid & slv_resp.w_ready;
      up_ar = slv_req.ar_valid & slv_resp.ar_ready;
      up_b  = slv_resp.b_valid & slv_req.b_ready;
      up_r  = slv_resp.r_valid & slv_req.r_ready;
      @(posedge clk);
      #0.5;
      act = (phase != 2'd0);
      // upstream bookkeeping
      if (up_aw) aw_idx++;
      if (up_w) w_idx++;
      if (up_ar) ar_idx++;
      if (up_b) b_cnt++;
      if (up_r) r_cnt++;
      // slave state and outputs
      for (int p = 0; p < `LD_NUM_PORTS; p++) begin
        if (aw_hs[p]) s_aw_q[p].push_back(aw_addr_s);
        if (w_hs[p]) s_w_q[p].push_back(w_data_s);
        if (ar_hs[p]) begin
          s_r_q[p].push_back(s_mem.exists({2'(p), ar_addr_s}) ?
                             s_mem[{2'(p), ar_addr_s}] : 32'h0);
        end
        if (b_hs[p]) s_b_pend[p]--;
        if (r_hs[p]) void'(s_r_q[p].pop_front());
        // commit the write once address and data are both in
        while (s_aw_q[p].size() > 0 && s_w_q[p].size() > 0) begin
          a = s_aw_q[p].pop_front();
          d = s_w_q[p].pop_front();
          s_mem[{2'(p), a}] = d;
          s_b_pend[p]++;
        end
        mst_resp[p].aw_ready = act & ready_bit(p);
        mst_resp[p].w_ready  = act & ready_bit(p);
        mst_resp[p].ar_ready = act & ready_bit(p);
        // a raised valid holds until taken
        if (!(mst_resp[p].b_valid && !b_hs[p])) begin
          mst_resp[p].b_valid = (s_b_pend[p] > 0) && ready_bit(p);
        end
        if (!(mst_resp[p].r_valid && !r_hs[p])) begin
          mst_resp[p].r_valid = !r_stall && (s_r_q[p].size() > 0) && ready_bit(p);
          mst_resp[p].r.data  = (s_r_q[p].size() > 0) ? s_r_q[p][0] : 32'h0;
        end
        // OKAY on a real response, idle slaves show SLVERR
        mst_resp[p].b.resp = mst_resp[p].b_valid ? 2'b00 : 2'b10;
        mst_resp[p].r.resp = mst_resp[p].r_valid ? 2'b00 : 2'b10;
      end
      // upstream master
      slv_req.aw_valid = (phase == 2'd1) && (aw_idx < nw);
      if (aw_idx < nw) begin
        slv_req.aw.addr = wr_addr[aw_idx];
        aw_sel          = wr_sel[aw_idx];
      end
      slv_req.w_valid = (phase == 2'd1) && (w_idx < nw);
      if (w_idx < nw) begin
        slv_req.w.data = wr_data[w_idx];
        slv_req.w.strb = 4'hf;
      end
      slv_req.ar_valid = (phase >= 2'd2) && (ar_idx < ar_lim);
      slv_req.ar.addr  = rd_addr[ar_idx % nr];
      ar_sel           = rd_sel[ar_idx % nr];
      slv_req.b_ready  = act & rnd_bit();
      slv_req.r_ready  = act & rnd_bit();
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    slv_req   = '0;
    // fixed protection bits on both address channels
    slv_req.aw.prot = 3'b010;
    slv_req.ar.prot = 3'b001;
    aw_sel    = '0;
    ar_sel    = '0;
    mst_resp  = '0;
    phase     = 2'd0;
    test_done = '0;
    r_stall   = 1'b0;
    lfsr_q    = 32'h5fa7_a665;
    aw_idx    = 0;
    w_idx     = 0;
    ar_idx    = 0;
    ar_lim    = 0;
    b_cnt     = 0;
    r_cnt     = 0;
    for (int p = 0; p < `LD_NUM_PORTS; p++) s_b_pend[p] = 0;
    // unused words keep op nibble f
    foreach (trace_mem[i]) trace_mem[i] = '1;
    $readmemh("dv/lite_demux_trace.txt", trace_mem);
    foreach (trace_mem[i]) begin
      if (trace_mem[i][103:100] == 4'h0) begin
        wr_sel.push_back(sel_t'(trace_mem[i][99:96]));
        wr_addr.push_back(trace_mem[i][95:64]);
        wr_data.push_back(trace_mem[i][63:32]);
      end else if (trace_mem[i][103:100] == 4'h1) begin
        rd_sel.push_back(sel_t'(trace_mem[i][99:96]));
        rd_addr.push_back(trace_mem[i][95:64]);
      end
    end
    nw      = wr_sel.size();
    nr      = rd_sel.size();
    n_lines = nw + nr;
    @(posedge rst_n);
    // idle window for the reset check
    repeat (3) wait_cycle();
    test_done[0] = 1'b1;
    phase = 2'd1;
    while (b_cnt != nw) wait_cycle();
    phase  = 2'd2;
    ar_lim = nr;
    while (r_cnt != nr) wait_cycle();
    // hold back R on every slave and replay the reads
    phase   = 2'd3;
    r_stall = 1'b1;
    ar_lim  = 2 * nr;
    while (ar_idx != nr + `LD_MAX_TRANS) wait_cycle();
    repeat (10) wait_cycle();
    r_stall = 1'b0;
    while (r_cnt != 2 * nr) wait_cycle();
    // routing and order checks watch every phase
    test_done[4:1] = 4'b1111;
    repeat (2) wait_cycle();
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == 5) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog allows 200 cycles per trace line
  initial begin
    wait (n_lines > 0);
    repeat (200 * n_lines) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

endmodule

/* dv/lite_demux_trace.txt */
// columns: op (0 write, 1 read) _ select _ address _ write data _ expected read data
// reads expect the last data written to that port and address
0_0_00000010_a0a00001_00000000
0_1_00000010_b1b10002_00000000
0_2_00000020_c2c20003_00000000
0_3_00000030_d3d30004_00000000
0_1_00000010_b1b10005_00000000
0_0_00000044_a0a00006_00000000
0_3_00000030_d3d30007_00000000
0_2_00000028_c2c20008_00000000
1_1_00000010_00000000_b1b10005
1_0_00000010_00000000_a0a00001
1_3_00000030_00000000_d3d30007
1_2_00000020_00000000_c2c20003
1_0_00000044_00000000_a0a00006
1_2_00000028_00000000_c2c20008
1_1_00000010_00000000_b1b10005

/* tb.f */
+incdir+src
src/lite_demux_pkg.sv
src/demux_sel_fifo.sv
src/demux_aw_route.sv
src/demux_ar_route.sv
src/demux_w_route.sv
src/demux_resp_route.sv
src/lite_demux.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_lite_demux.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the lite_demux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_lite_demux \
  --Mdir obj_dir -o sim_lite_demux
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_lite_demux > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0
